//--- all.f
hdl/cpu_types_pkg.sv
hdl/datapath_cache_if.sv
hdl/cache_control_if.sv
hdl/fetch_sequencer.sv
hdl/icache.sv
hdl/memory_controller.sv
hdl/fetch_top.sv
sim/ram_model.sv
sim/tb_fetch_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_fetch_top
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All checks passed
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_fetch_top.sv
`timescale 1ns/1ns

module tb_fetch_top;
	import cpu_types_pkg::*;

	localparam int SETS = 16;
	localparam int WORDS_PER_BLK = 1;
	localparam int MEM_LATENCY = 3;
	localparam int BLK_BITS = $clog2(WORDS_PER_BLK);

	localparam int FETCH_TIMEOUT = 200;
	localparam int HALT_TIMEOUT = 2 * SETS + 50;

	// Program regions
	localparam word_t COLD_PC = 32'h0000_0100;
	localparam int COLD_LEN = 20;
	localparam word_t LOOP_PC = 32'h0000_0200;
	localparam int LOOP_LEN = 5;
	localparam word_t CONF_A = 32'h0000_0300;
	localparam word_t CONF_B = CONF_A + word_t'(SETS * WORDS_PER_BLK * 4);
	localparam word_t RAND_BASE = 32'h0000_1000;

	logic CLK;
	logic nRST;
	logic start;
	word_t start_pc;
	logic redirect;
	word_t redirect_pc;
	logic halt;
	word_t ram_rdata;
	logic instr_valid;
	word_t instr;
	word_t instr_pc;
	logic halted;
	logic ram_ren;
	word_t ram_addr;

	string test_name;
	word_t rng;
	word_t exp_pc;
	int fetch_reads;
	int ram_total;
	int ref_total;
	logic ref_valid [SETS];
	word_t ref_tag [SETS];

	fetch_top #(
		.SETS(SETS),
		.WORDS_PER_BLK(WORDS_PER_BLK),
		.MEM_LATENCY(MEM_LATENCY)
	) fetch_top_i (
		.CLK(CLK),
		.nRST(nRST),
		.start(start),
		.start_pc(start_pc),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.halt(halt),
		.ram_rdata(ram_rdata),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.halted(halted),
		.ram_ren(ram_ren),
		.ram_addr(ram_addr)
	);

	ram_model ram_model_i (
		.CLK(CLK),
		.nRST(nRST),
		.ren(ram_ren),
		.addr(ram_addr),
		.rdata(ram_rdata)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Expected RAM contents for a byte address
	function automatic word_t mem_word(word_t a);
		word_t w;
		word_t h;
		w = a & ~word_t'(3);
		h = w * 32'h9E37_79B1;
		h = h ^ (h >> 16);
		h = h + {w[7:0], w[31:8]};
		return h;
	endfunction

	function automatic word_t blk_base(word_t a);
		return (a >> (2 + BLK_BITS)) << (2 + BLK_BITS);
	endfunction

	// Direct mapped tag model, returns the RAM reads this fetch costs
	function automatic int ref_cache(word_t pc);
		word_t blk;
		word_t tag;
		int idx;
		blk = pc >> (2 + BLK_BITS);
		idx = int'(blk % word_t'(SETS));
		tag = blk / word_t'(SETS);
		if (ref_valid[idx] && ref_tag[idx] == tag) begin
			return 0;
		end
		ref_valid[idx] = 1'b1;
		ref_tag[idx] = tag;
		return WORDS_PER_BLK;
	endfunction

	function automatic void ref_clear();
		for (int s = 0; s < SETS; s++) begin
			ref_valid[s] = 1'b0;
		end
	endfunction

	function automatic word_t xorshift(word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Word aligned target inside a 64 word window
	function automatic word_t rand_target();
		rng = xorshift(rng);
		return RAND_BASE + (rng & 32'h0000_00FC);
	endfunction

	task automatic fail_stop();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(string what, word_t exp_val, word_t act_val);
		$display("** Error [%s] %s: expected %h, actual %h",
			test_name, what, exp_val, act_val);
		fail_stop();
	endtask

	task automatic report_problem(string what);
		$display("Test %s failed: %s", test_name, what);
		fail_stop();
	endtask

	// Returns 5 ns into the cycle where instr_valid is high
	task automatic next_fetch(output word_t pc);
		int cycles;
		cycles = 0;
		do begin
			@(posedge CLK);
			#5;
			start = 1'b0;
			redirect = 1'b0;
			cycles++;
			if (cycles > FETCH_TIMEOUT) begin
				report_problem("no instruction arrived before the timeout");
			end
		end while (!instr_valid);
		pc = instr_pc;
	endtask

	always @(negedge CLK) begin
		int exp_reads;
		if (!nRST || halted) begin
			ref_clear();
			fetch_reads = 0;
		end
		if (nRST && ram_ren) begin
			assert (ram_addr == blk_base(exp_pc) + word_t'(4 * fetch_reads))
				else report_mismatch("refill address",
					blk_base(exp_pc) + word_t'(4 * fetch_reads), ram_addr);
			fetch_reads++;
			ram_total++;
		end
		if (nRST && instr_valid) begin
			assert (!halted) else report_problem("instruction delivered after halted");
			assert (instr_pc == exp_pc) else report_mismatch("instr_pc", exp_pc, instr_pc);
			assert (instr == mem_word(instr_pc))
				else report_mismatch("instr", mem_word(instr_pc), instr);
			exp_reads = ref_cache(instr_pc);
			assert (fetch_reads == exp_reads)
				else report_mismatch("RAM reads for fetch",
					word_t'(exp_reads), word_t'(fetch_reads));
			ref_total += exp_reads;
			fetch_reads = 0;
			// A redirect in this cycle picks the next address
			exp_pc = redirect ? redirect_pc : instr_pc + word_t'(4);
		end
		if (nRST && start) begin
			exp_pc = start_pc;
			fetch_reads = 0;
		end
	end

	initial begin
		word_t pc;
		word_t last_pc;
		int mark;
		int cycles;
		int i;
		int pass;
		nRST = 1'b0;
		start = 1'b0;
		start_pc = '0;
		redirect = 1'b0;
		redirect_pc = '0;
		halt = 1'b0;
		rng = 32'd2554;
		exp_pc = '0;
		fetch_reads = 0;
		ram_total = 0;
		ref_total = 0;
		test_name = "reset";
		repeat (10) @(posedge CLK);
		#5;
		nRST = 1'b1;

		test_name = "sequential cold fetch";
		@(posedge CLK);
		#5;
		start_pc = COLD_PC;
		start = 1'b1;
		for (i = 0; i < COLD_LEN; i++) begin
			next_fetch(pc);
		end
		redirect = 1'b1;
		redirect_pc = LOOP_PC;

		// Totals include the last fetch once the compare process has seen it
		@(negedge CLK);
		#1;
		test_name = "miss refill traffic";
		assert (ram_total == ref_total)
			else report_mismatch("total RAM reads", word_t'(ref_total), word_t'(ram_total));

		test_name = "loop reuse";
		mark = 0;
		for (pass = 0; pass < 4; pass++) begin
			for (i = 0; i < LOOP_LEN; i++) begin
				next_fetch(pc);
			end
			if (pass == 0) begin
				mark = ram_total;
			end
			redirect = 1'b1;
			redirect_pc = (pass < 3) ? LOOP_PC : CONF_A;
		end
		assert (ram_total == mark)
			else report_mismatch("RAM reads after first pass", word_t'(mark), word_t'(ram_total));

		test_name = "conflict eviction";
		mark = ram_total;
		for (i = 0; i < 8; i++) begin
			next_fetch(pc);
			redirect = 1'b1;
			if (i == 7) begin
				redirect_pc = rand_target();
			end else begin
				redirect_pc = (pc == CONF_A) ? CONF_B : CONF_A;
			end
		end
		assert (ram_total - mark == 8 * WORDS_PER_BLK)
			else report_mismatch("conflict RAM reads", word_t'(8 * WORDS_PER_BLK),
				word_t'(ram_total - mark));

		test_name = "random redirects";
		for (i = 0; i < 200; i++) begin
			next_fetch(pc);
			if (i < 199) begin
				redirect = 1'b1;
				redirect_pc = rand_target();
			end
		end
		// Halt lands in the last valid cycle so nothing new is issued
		last_pc = pc;
		halt = 1'b1;
		@(negedge CLK);
		#1;
		assert (ram_total == ref_total)
			else report_mismatch("total RAM reads", word_t'(ref_total), word_t'(ram_total));

		test_name = "halt";
		cycles = 0;
		while (!halted) begin
			@(posedge CLK);
			#5;
			cycles++;
			assert (!instr_valid) else report_problem("instruction delivered after halt");
			if (cycles > HALT_TIMEOUT) begin
				report_problem("halted did not rise before the timeout");
			end
		end
		repeat (20) @(posedge CLK);
		#5;
		nRST = 1'b0;
		halt = 1'b0;
		repeat (4) @(posedge CLK);
		#5;
		nRST = 1'b1;
		@(posedge CLK);
		#5;
		mark = ram_total;
		start_pc = last_pc;
		start = 1'b1;
		next_fetch(pc);
		assert (ram_total - mark == WORDS_PER_BLK)
			else report_mismatch("RAM reads after halt", word_t'(WORDS_PER_BLK),
				word_t'(ram_total - mark));

		$display("All checks passed");
		$finish;
	end

endmodule

//--- sim/ram_model.sv
`timescale 1ns/1ns

module ram_model (
	input logic CLK,
	input logic nRST,
	input logic ren,
	input cpu_types_pkg::word_t addr,
	output cpu_types_pkg::word_t rdata
);
	import cpu_types_pkg::*;

	// Word contents are a hash of the word address
	function automatic word_t contents(word_t a);
		word_t w;
		word_t h;
		w = {a[31:2], 2'b00};
		h = w * 32'h9E37_79B1;
		h = h ^ (h >> 16);
		h = h + {w[7:0], w[31:8]};
		return h;
	endfunction

	// Read data shows up the cycle after ren and is held
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rdata <= '0;
		end else if (ren) begin
			rdata <= contents(addr);
		end
	end

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
	parameter int SETS = 16,
	parameter int WORDS_PER_BLK = 1,
	parameter int MEM_LATENCY = 3
) (
	input logic CLK,
	input logic nRST,
	input logic start,
	input cpu_types_pkg::word_t start_pc,
	input logic redirect,
	input cpu_types_pkg::word_t redirect_pc,
	input logic halt,
	input cpu_types_pkg::word_t ram_rdata,
	output logic instr_valid,
	output cpu_types_pkg::word_t instr,
	output cpu_types_pkg::word_t instr_pc,
	output logic halted,
	output logic ram_ren,
	output cpu_types_pkg::word_t ram_addr
);

	// Sequencer to cache
	datapath_cache_if dcif ();

	// Cache to memory controller
	cache_control_if ccif ();

	logic halt_req;

	fetch_sequencer fetch_sequencer_i (
		.CLK(CLK),
		.nRST(nRST),
		.start(start),
		.start_pc(start_pc),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.halt(halt),
		.dcif(dcif.fetch),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.halt_req(halt_req)
	);

	icache #(
		.SETS(SETS),
		.WORDS_PER_BLK(WORDS_PER_BLK)
	) icache_i (
		.CLK(CLK),
		.nRST(nRST),
		.halt_req(halt_req),
		.dcif(dcif.icache),
		.ccif(ccif.icache),
		.halted(halted)
	);

	memory_controller #(
		.MEM_LATENCY(MEM_LATENCY)
	) memory_controller_i (
		.CLK(CLK),
		.nRST(nRST),
		.ccif(ccif.memctl),
		.ram_ren(ram_ren),
		.ram_addr(ram_addr),
		.ram_rdata(ram_rdata)
	);

endmodule

//--- hdl/memory_controller.sv
`timescale 1ns/1ns

module memory_controller #(
	parameter int MEM_LATENCY = 3
) (
	input logic CLK,
	input logic nRST,
	cache_control_if.memctl ccif,
	output logic ram_ren,
	output cpu_types_pkg::word_t ram_addr,
	input cpu_types_pkg::word_t ram_rdata
);
	import cpu_types_pkg::*;

	// Needs MEM_LATENCY of at least one
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	mem_state_t state;
	logic [LAT_W-1:0] lat_cnt;
	logic lat_done;
	word_t rdata_q;
	icachef_t raddr;

	assign lat_done = (lat_cnt == LAT_W'(MEM_LATENCY - 1));

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= MEM_IDLE;
			lat_cnt <= '0;
		end else begin
			case (state)
				MEM_IDLE: begin
					lat_cnt <= '0;
					if (ccif.iREN) begin
						state <= MEM_WAIT;
					end
				end
				MEM_WAIT: begin
					if (lat_done) begin
						state <= MEM_DONE;
					end else begin
						lat_cnt <= lat_cnt + 1'b1;
					end
				end
				MEM_DONE: begin
					state <= MEM_IDLE;
				end
				default: begin
					state <= MEM_IDLE;
				end
			endcase
		end
	end

	// RAM data is stable from the first wait cycle on
	always_ff @(posedge CLK) begin
		if (state == MEM_WAIT && lat_done) begin
			rdata_q <= ram_rdata;
		end
	end

	// RAM reads whole words, so the byte offset is dropped
	always_comb begin
		raddr = icachef_t'(ccif.iaddr);
		raddr.off[1:0] = 2'b00;
	end

	// One read strobe per requested word, issued in the cycle iREN is seen
	assign ram_ren = (state == MEM_IDLE) && ccif.iREN;
	assign ram_addr = word_t'(raddr);

	assign ccif.iwait = (state != MEM_DONE);
	assign ccif.iload = rdata_q;

endmodule

//--- hdl/icache.sv
`timescale 1ns/1ns

module icache #(
	parameter int SETS = 16,
	parameter int WORDS_PER_BLK = 1
) (
	input logic CLK,
	input logic nRST,
	input logic halt_req,
	datapath_cache_if.icache dcif,
	cache_control_if.icache ccif,
	output logic halted
);
	import cpu_types_pkg::*;

	// Word select keeps one bit even for single word blocks
	localparam int WSEL_W = (IBLK_W > 0) ? IBLK_W : 1;
	localparam int SCNT_W = (SETS > 1) ? $clog2(SETS) : 1;

	icache_state_t state;

	// Request address split into cache fields
	icachef_t req;
	logic [WSEL_W-1:0] req_word;
	logic tag_hit;

	// Refill progress
	logic [WSEL_W-1:0] fill_cnt;
	logic fill_last;
	word_t blk_base;

	// Halt sweep position
	logic [SCNT_W-1:0] sweep_cnt;

	// Line storage
	logic [SETS-1:0] valid;
	logic [ITAG_W-1:0] tags [SETS];
	word_t data [SETS][WORDS_PER_BLK];

	assign req = icachef_t'(dcif.imemaddr);
	assign req_word = WSEL_W'(req.off >> 2);
	assign tag_hit = valid[req.idx] && (tags[req.idx] == req.tag);

	assign fill_last = (fill_cnt == WSEL_W'(WORDS_PER_BLK - 1));

	// First byte of the block holding the request
	assign blk_base = word_t'({req.tag, req.idx, {(IBLK_W + 2){1'b0}}});

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			fill_cnt <= '0;
			sweep_cnt <= '0;
			valid <= '0;
		end else begin
			case (state)
				IDLE: begin
					fill_cnt <= '0;
					sweep_cnt <= '0;
					// Halt only arrives with no fetch outstanding
					if (halt_req) begin
						state <= HALT;
					end else if (dcif.imemREN && tag_hit) begin
						state <= READ;
					end else if (dcif.imemREN) begin
						state <= ALLOC_RD;
					end
				end
				READ: begin
					// ihit is high for exactly this cycle
					state <= IDLE;
				end
				ALLOC_RD: begin
					// Stall here as long as memory holds iwait
					if (!ccif.iwait) begin
						if (fill_last) begin
							valid[req.idx] <= 1'b1;
							state <= READ;
						end else begin
							fill_cnt <= fill_cnt + 1'b1;
						end
					end
				end
				HALT: begin
					// One set per cycle
					valid[sweep_cnt] <= 1'b0;
					if (sweep_cnt == SCNT_W'(SETS - 1)) begin
						state <= HALTED;
					end else begin
						sweep_cnt <= sweep_cnt + 1'b1;
					end
				end
				HALTED: begin
					state <= HALTED;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Refill writes, one word per released iwait
	always_ff @(posedge CLK) begin
		if (state == ALLOC_RD && !ccif.iwait) begin
			data[req.idx][fill_cnt] <= ccif.iload;
			if (fill_last) begin
				tags[req.idx] <= req.tag;
			end
		end
	end

	// Hit pulse comes straight from the state register
	assign dcif.ihit = (state == READ);
	assign dcif.imemload = data[req.idx][req_word];

	// Words of the block are requested in order
	assign ccif.iREN = (state == ALLOC_RD);
	assign ccif.iaddr = blk_base + (word_t'(fill_cnt) << 2);

	assign halted = (state == HALTED);

endmodule

//--- hdl/fetch_sequencer.sv
`timescale 1ns/1ns

module fetch_sequencer (
	input logic CLK,
	input logic nRST,
	input logic start,
	input cpu_types_pkg::word_t start_pc,
	input logic redirect,
	input cpu_types_pkg::word_t redirect_pc,
	input logic halt,
	datapath_cache_if.fetch dcif,
	output logic instr_valid,
	output cpu_types_pkg::word_t instr,
	output cpu_types_pkg::word_t instr_pc,
	output logic halt_req
);
	import cpu_types_pkg::*;

	word_t pc;
	word_t next_pc;
	word_t redir_pc;
	word_t issue_pc;
	logic redir_pend;
	logic running;
	logic halting;
	logic req;
	logic done;
	logic issue;

	assign done = req && dcif.ihit;

	// Next request leaves after the idle cycle that follows ihit
	assign issue = running && !halting && !halt && !req;

	// A redirect seen now beats one stored earlier
	always_comb begin
		if (redirect) begin
			issue_pc = redirect_pc;
		end else if (redir_pend) begin
			issue_pc = redir_pc;
		end else begin
			issue_pc = next_pc;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			req <= 1'b0;
			running <= 1'b0;
			halting <= 1'b0;
			redir_pend <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			instr_valid <= done;
			if (done) begin
				req <= 1'b0;
			end else if (issue) begin
				req <= 1'b1;
			end
			if (halt) begin
				halting <= 1'b1;
				running <= 1'b0;
			end else if (start && !halting) begin
				running <= 1'b1;
			end
			if (start || issue) begin
				redir_pend <= 1'b0;
			end else if (redirect) begin
				redir_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (start) begin
			next_pc <= start_pc;
		end else if (issue) begin
			next_pc <= issue_pc + word_t'(4);
		end
		if (issue) begin
			pc <= issue_pc;
		end
		if (redirect) begin
			redir_pc <= redirect_pc;
		end
		if (done) begin
			instr <= dcif.imemload;
			instr_pc <= pc;
		end
	end

	assign dcif.imemREN = req;
	assign dcif.imemaddr = pc;

	// Cache may only start its sweep with nothing in flight
	assign halt_req = halting && !req;

endmodule

//--- hdl/cache_control_if.sv
`timescale 1ns/1ns

interface cache_control_if;
	import cpu_types_pkg::*;

	// Refill read, one word address at a time
	logic iREN;
	word_t iaddr;

	// iwait drops for one cycle while iload is valid
	logic iwait;
	word_t iload;

	modport icache (
		output iREN, iaddr,
		input iwait, iload
	);

	modport memctl (
		input iREN, iaddr,
		output iwait, iload
	);
endinterface

//--- hdl/datapath_cache_if.sv
`timescale 1ns/1ns

interface datapath_cache_if;
	import cpu_types_pkg::*;

	// Request level and address, held until the cycle after ihit
	logic imemREN;
	word_t imemaddr;

	// One cycle hit pulse with the instruction
	logic ihit;
	word_t imemload;

	modport fetch (
		output imemREN, imemaddr,
		input ihit, imemload
	);

	modport icache (
		input imemREN, imemaddr,
		output ihit, imemload
	);
endinterface

//--- hdl/cpu_types_pkg.sv
package cpu_types_pkg;

	// Machine word
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// Default instruction cache geometry
	localparam int ISETS = 16;
	localparam int IWORDS = 1;

	// Address field widths
	localparam int IIDX_W = $clog2(ISETS);
	localparam int IBLK_W = $clog2(IWORDS);
	localparam int ITAG_W = WORD_W - 2 - IIDX_W - IBLK_W;

	// Byte address as the cache sees it.
	// The low two bits of off are the byte offset and the bits above
	// them select the word in the block, so with one word per block
	// only the byte offset is left
	typedef struct packed {
		logic [ITAG_W-1:0] tag;
		logic [IIDX_W-1:0] idx;
		logic [IBLK_W+1:0] off;
	} icachef_t;

	// Instruction cache FSM
	typedef enum logic [2:0] {
		IDLE,
		READ,
		ALLOC_RD,
		HALT,
		HALTED
	} icache_state_t;

	// Memory controller FSM.
	// Prefixed since IDLE already belongs to the cache states
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WAIT,
		MEM_DONE
	} mem_state_t;

endpackage
